//--- verification/ctr_stimulus.txt
// Columns: test id, initial counter, block count, stall flag, error flag, final counter
// All hex; a record with id ff ends the list
// Single block returned unchanged
01 0123456789abcdef0011223344556677 01 0 0 0123456789abcdef0011223344556678
// Low slices all ones, carry ripples upward
02 00000000000000000000fffffffffffe 03 0 0 00000000000000000001000000000001
// Wrap-around from all ones to zero
03 ffffffffffffffffffffffffffffffff 02 0 0 00000000000000000000000000000001
// Random output stalls
04 5a5a5a5a5a5a5a5a5a5a5a5a5a5afffc 06 1 0 5a5a5a5a5a5a5a5a5a5a5a5a5a5b0002
// Error raised mid-run, then reset
05 00000000000000000000000000000100 14 0 1 00000000000000000000000000000114
// Normal run after the error reset
06 deadbeefcafef00d0123456789abcdef 02 1 0 deadbeefcafef00d0123456789abcdf1
// Zero count loads only
07 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f 00 0 0 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f
// Carry through every slice under stalls
08 7fffffffffffffffffffffffffffffff 03 1 0 80000000000000000000000000000002
// End marker
ff 0 0 0 0 0

//--- list.f
src/ctr_pkg.sv
src/ctr_incr_fsm.sv
src/ctr_block_gen.sv
src/ctr_block_fifo.sv
src/ctr_word_serializer.sv
src/ctr_stream_top.sv
verification/tb_clock_gen.sv
verification/tb_ctr_stream.sv

//--- verification/tb_ctr_stream.sv
/*
 * Counter stream testbench
 * Reads test records, runs block requests with optional stalls and error
 * injection, and checks every output word against the counting rule
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ctr_stream;

  localparam int MaxRecords      = 16;
  localparam int RecordFields    = 6;
  localparam int CyclesPerBlock  = 40;
  localparam int WatchdogMargin  = 500;
  localparam int ErrorAfterWords = 6;
  localparam int ErrorHoldCycles = 10;
  localparam int ReadyWaitCycles = 40;
  localparam int QuietCycles     = 4;

  wire                               clk;
  wire                               rst_n;
  logic                              reset_req;

  // DUT inputs
  logic                              err;
  logic                              start_valid;
  logic [ctr_pkg::CtrWidth-1:0]      start_iv;
  logic [ctr_pkg::CountWidth-1:0]    start_count;
  logic                              out_ready;
  // DUT outputs
  wire                               alert;
  wire                               start_ready;
  wire                               out_valid;
  wire  [ctr_pkg::WordWidth-1:0]     out_word;

  // Six fields per record
  logic [127:0]                      stim_mem [RecordFields*MaxRecords];
  int                                num_records;
  int                                total_blocks;
  int                                watchdog_cycles;
  int                                check_count;
  int                                error_count;
  logic [31:0]                       rng_state;

  tb_clock_gen i_clock_gen (
    .rst_req_i (reset_req),
    .clk_o     (clk),
    .rst_no    (rst_n)
  );

  ctr_stream_top i_dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .err_i         (err),
    .alert_o       (alert),
    .start_valid_i (start_valid),
    .start_ready_o (start_ready),
    .start_iv_i    (start_iv),
    .start_count_i (start_count),
    .out_valid_o   (out_valid),
    .out_ready_i   (out_ready),
    .out_word_o    (out_word)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("ERROR: %s", what);
  endtask

  // Quiet state after any reset
  task automatic check_idle(input string name);
    check_value({name, " alert_o"}, 1'b0, alert);
    check_value({name, " start_ready_o"}, 1'b1, start_ready);
    check_value({name, " out_valid_o"}, 1'b0, out_valid);
  endtask

  task automatic start_run(input logic [127:0] iv, input logic [ctr_pkg::CountWidth-1:0] count);
    @(negedge clk);
    start_valid = 1'b1;
    start_iv    = iv;
    start_count = count;
    // Taken on the next rising edge with ready high
    while (!start_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    start_valid = 1'b0;
  endtask

  task automatic collect_words(input string name, input logic [127:0] iv,
                               input int num_words, input bit stall);
    logic [127:0] blk;
    logic [31:0]  exp_word;
    logic [31:0]  held_word;
    bit           held;
    int           taken;
    taken = 0;
    held  = 1'b0;
    while (taken < num_words) begin
      @(negedge clk);
      // A stalled word must not move
      if (held) begin
        check_value($sformatf("%s stalled word %0d", name, taken), held_word, out_word);
      end
      if (stall) begin
        rng_state = xorshift32(rng_state);
        out_ready = rng_state[4];
      end else begin
        out_ready = 1'b1;
      end
      held      = out_valid && !out_ready;
      held_word = out_word;
      // Word accepted on the coming rising edge
      if (out_valid && out_ready) begin
        blk      = iv + 128'(taken / ctr_pkg::WordsPerBlock);
        exp_word = 32'(blk >> (ctr_pkg::WordWidth *
                   (ctr_pkg::WordsPerBlock - 1 - taken % ctr_pkg::WordsPerBlock)));
        check_value($sformatf("%s word %0d", name, taken), exp_word, out_word);
        taken++;
      end
    end
  endtask

  task automatic finish_run(input string name);
    int waited;
    bit extra;
    waited = 0;
    extra  = 1'b0;
    // Generator idles once its last increment is done
    // No word may show up on the way there or after it
    while (!start_ready && waited < ReadyWaitCycles) begin
      @(negedge clk);
      waited++;
      if (out_valid) begin
        extra = 1'b1;
      end
    end
    if (!start_ready) begin
      report_failure({name, ": start_ready_o did not return high after the run"});
    end
    repeat (QuietCycles) begin
      @(negedge clk);
      if (out_valid) begin
        extra = 1'b1;
      end
    end
    if (extra) begin
      report_failure({name, ": an extra word appeared after the last block"});
    end
  endtask

  task automatic inject_error(input string name);
    @(negedge clk);
    err = 1'b1;
    @(negedge clk);
    err = 1'b0;
    repeat (ErrorHoldCycles) begin
      check_value({name, " alert_o"}, 1'b1, alert);
      check_value({name, " out_valid_o"}, 1'b0, out_valid);
      check_value({name, " start_ready_o"}, 1'b0, start_ready);
      @(negedge clk);
    end
    // Terminal state cleared by reset only
    reset_req = 1'b1;
    @(posedge rst_n);
    reset_req = 1'b0;
    check_idle({name, " after reset"});
  endtask

  task automatic run_record(input int rec);
    logic [7:0]                     id;
    logic [127:0]                   iv;
    logic [127:0]                   final_blk;
    logic [ctr_pkg::CountWidth-1:0] count;
    bit                             stall;
    bit                             inject;
    string                          name;
    id        = stim_mem[rec*RecordFields][7:0];
    iv        = stim_mem[rec*RecordFields+1];
    count     = stim_mem[rec*RecordFields+2][ctr_pkg::CountWidth-1:0];
    stall     = stim_mem[rec*RecordFields+3][0];
    inject    = stim_mem[rec*RecordFields+4][0];
    final_blk = stim_mem[rec*RecordFields+5];
    name      = $sformatf("test_%0d", id);
    // Final block is the start value plus the run length
    check_value({name, " final counter"}, final_blk, iv + 128'(count));
    start_run(iv, count);
    if (inject) begin
      collect_words(name, iv, ErrorAfterWords, stall);
      inject_error(name);
    end else begin
      collect_words(name, iv, int'(count) * ctr_pkg::WordsPerBlock, stall);
      finish_run(name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    reset_req   = 1'b0;
    err         = 1'b0;
    start_valid = 1'b0;
    start_iv    = '0;
    start_count = '0;
    out_ready   = 1'b0;
    check_count = 0;
    error_count = 0;
    rng_state   = 32'd32;
    $readmemh("verification/ctr_stimulus.txt", stim_mem);
    num_records  = 0;
    total_blocks = 0;
    // Records end at the ff marker
    while (num_records < MaxRecords &&
           !$isunknown(stim_mem[num_records*RecordFields]) &&
           stim_mem[num_records*RecordFields][7:0] != 8'hff) begin
      total_blocks += int'(stim_mem[num_records*RecordFields+2][7:0]);
      num_records++;
    end
    if (num_records == 0) begin
      report_failure("no test records found in the stimulus file");
    end
    watchdog_cycles = total_blocks * CyclesPerBlock + WatchdogMargin;
    wait (rst_n === 1'b1);
    check_idle("reset");
    for (int rec = 0; rec < num_records; rec++) begin
      run_record(rec);
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog armed once the run length is known
  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles before all tests finished", watchdog_cycles);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
/*
 * Testbench clock and reset generator
 * 100 ns clock, reset low for two cycles at start and again on request
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  input  wire  rst_req_i,
  output logic clk_o,
  output logic rst_no
);

  // Half of the 100 ns period
  localparam time HalfPeriod = 50;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Reset spans two rising edges, released on a falling edge
  always begin
    rst_no = 1'b0;
    repeat (2) @(negedge clk_o);
    rst_no = 1'b1;
    @(posedge rst_req_i);
  end

endmodule

`default_nettype wire

//--- src/ctr_stream_top.sv
/*
 * Counter stream top level
 * Block generator, block FIFO and word serializer in a chain
 */
`timescale 1ns/1ps
`default_nettype none

module ctr_stream_top (
  input  wire                              clk_i,
  input  wire                              rst_ni,
  input  wire                              err_i,
  output logic                             alert_o,
  input  wire                              start_valid_i,
  output logic                             start_ready_o,
  input  wire  [ctr_pkg::CtrWidth-1:0]     start_iv_i,
  input  wire  [ctr_pkg::CountWidth-1:0]   start_count_i,
  output logic                             out_valid_o,
  input  wire                              out_ready_i,
  output logic [ctr_pkg::WordWidth-1:0]    out_word_o
);

  // Generator to FIFO
  logic                         push_valid, push_ready;
  logic [ctr_pkg::CtrWidth-1:0] push_block;
  // FIFO to serializer
  logic                         pop_valid, pop_ready;
  logic [ctr_pkg::CtrWidth-1:0] pop_block;
  // Alert fans out to flush and drop
  logic                         alert;

  assign alert_o = alert;

  ctr_block_gen i_block_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_valid_i (start_valid_i),
    .start_ready_o (start_ready_o),
    .start_iv_i    (start_iv_i),
    .start_count_i (start_count_i),
    .err_i         (err_i),
    .alert_o       (alert),
    .push_valid_o  (push_valid),
    .push_block_o  (push_block),
    .push_ready_i  (push_ready)
  );

  ctr_block_fifo i_block_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (alert),
    .push_valid_i (push_valid),
    .push_ready_o (push_ready),
    .push_block_i (push_block),
    .pop_valid_o  (pop_valid),
    .pop_ready_i  (pop_ready),
    .pop_block_o  (pop_block)
  );

  ctr_word_serializer i_word_serializer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .drop_i      (alert),
    .in_valid_i  (pop_valid),
    .in_ready_o  (pop_ready),
    .in_block_i  (pop_block),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_word_o  (out_word_o)
  );

endmodule

`default_nettype wire

//--- src/ctr_word_serializer.sv
/*
 * Counter block word serializer
 * Holds one block and emits it as words, most significant first,
 * under valid/ready back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module ctr_word_serializer (
  input  wire                            clk_i,
  input  wire                            rst_ni,
  input  wire                            drop_i,

  // Block input
  input  wire                            in_valid_i,
  output logic                           in_ready_o,
  input  wire  [ctr_pkg::CtrWidth-1:0]   in_block_i,

  // Word output
  output logic                           out_valid_o,
  input  wire                            out_ready_i,
  output logic [ctr_pkg::WordWidth-1:0]  out_word_o
);

  logic                              full_q;
  logic [ctr_pkg::WordIdxWidth-1:0]  word_idx_q;
  logic [ctr_pkg::CtrWidth-1:0]      block_q;
  logic                              in_fire, out_fire;

  // Load only when empty
  assign in_ready_o  = !full_q && !drop_i;
  assign out_valid_o = full_q && !drop_i;
  // Current word always sits at the top
  assign out_word_o  = block_q[ctr_pkg::CtrWidth-1 -: ctr_pkg::WordWidth];

  assign in_fire  = in_valid_i && in_ready_o;
  assign out_fire = out_valid_o && out_ready_i;

  // Occupancy and word index
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q     <= 1'b0;
      word_idx_q <= '0;
    end else if (drop_i) begin
      full_q     <= 1'b0;
      word_idx_q <= '0;
    end else if (in_fire) begin
      full_q     <= 1'b1;
      word_idx_q <= '0;
    end else if (out_fire) begin
      // Free after the fourth word
      if (word_idx_q == ctr_pkg::LastWordIdx) begin
        full_q <= 1'b0;
      end
      word_idx_q <= word_idx_q + 1'b1;
    end
  end

  // Block shifts up one word per transfer
  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      block_q <= in_block_i;
    end else if (out_fire) begin
      block_q <= block_q << ctr_pkg::WordWidth;
    end
  end

endmodule

`default_nettype wire

//--- src/ctr_block_fifo.sv
/*
 * Counter block FIFO
 * Circular buffer of counter blocks with valid/ready on both sides
 * and a flush that empties it
 */
`timescale 1ns/1ps
`default_nettype none

module ctr_block_fifo (
  input  wire                           clk_i,
  input  wire                           rst_ni,
  input  wire                           flush_i,

  // Write side
  input  wire                           push_valid_i,
  output logic                          push_ready_o,
  input  wire  [ctr_pkg::CtrWidth-1:0]  push_block_i,

  // Read side
  output logic                          pop_valid_o,
  input  wire                           pop_ready_i,
  output logic [ctr_pkg::CtrWidth-1:0]  pop_block_o
);

  logic [ctr_pkg::CtrWidth-1:0]     mem_q [ctr_pkg::FifoDepth];
  logic [ctr_pkg::FifoPtrWidth-1:0] wptr_q, rptr_q;
  logic [ctr_pkg::FifoCntWidth-1:0] cnt_q;
  logic                             push_fire, pop_fire;

  // Handshakes
  assign push_ready_o = (cnt_q != ctr_pkg::FifoFullCnt) && !flush_i;
  assign pop_valid_o  = (cnt_q != '0);
  assign pop_block_o  = mem_q[rptr_q];

  assign push_fire = push_valid_i && push_ready_o;
  assign pop_fire  = pop_valid_o && pop_ready_i;

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      // Drop everything held
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push_fire) begin
        wptr_q <= (wptr_q == ctr_pkg::LastFifoPtr) ? '0 : wptr_q + 1'b1;
      end
      if (pop_fire) begin
        rptr_q <= (rptr_q == ctr_pkg::LastFifoPtr) ? '0 : rptr_q + 1'b1;
      end
      case ({push_fire, pop_fire})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem_q[wptr_q] <= push_block_i;
    end
  end

endmodule

`default_nettype wire

//--- src/ctr_block_gen.sv
/*
 * Counter block generator
 * Holds the counter block, pushes a requested run of consecutive blocks
 * and steps the counter through the increment FSM between them
 */
`timescale 1ns/1ps
`default_nettype none

module ctr_block_gen (
  input  wire                              clk_i,
  input  wire                              rst_ni,

  // Start request
  input  wire                              start_valid_i,
  output logic                             start_ready_o,
  input  wire  [ctr_pkg::CtrWidth-1:0]     start_iv_i,
  input  wire  [ctr_pkg::CountWidth-1:0]   start_count_i,

  // Error in, alert out
  input  wire                              err_i,
  output logic                             alert_o,

  // Block push towards the FIFO
  output logic                             push_valid_o,
  output logic [ctr_pkg::CtrWidth-1:0]     push_block_o,
  input  wire                              push_ready_i
);

  // Run sequencing
  typedef enum logic [1:0] {
    GEN_IDLE = 2'b00,
    GEN_PUSH = 2'b01,
    GEN_INCR = 2'b10
  } gen_state_e;

  gen_state_e                          state_d, state_q;
  logic [ctr_pkg::CountWidth-1:0]      rem_d, rem_q;
  logic [ctr_pkg::CtrWidth-1:0]        ctr_q;
  ctr_pkg::ctr_state_e                 incr_view;

  logic                                start_fire, push_fire, incr_done;
  logic                                fsm_ready, slice_we;
  logic [ctr_pkg::SliceIdxWidth-1:0]   slice_idx;
  logic [ctr_pkg::SliceSize-1:0]       slice_rd, slice_wr;

  // Coarse view of the increment FSM for the idle test
  assign incr_view = alert_o   ? ctr_pkg::CTR_ERROR :
                     fsm_ready ? ctr_pkg::CTR_IDLE  : ctr_pkg::CTR_INCR;

  assign start_ready_o = (state_q == GEN_IDLE) && (incr_view == ctr_pkg::CTR_IDLE);
  assign start_fire    = start_valid_i && start_ready_o;

  // Nothing leaves while the alert is up
  assign push_valid_o = (state_q == GEN_PUSH) && !alert_o;
  assign push_block_o = ctr_q;
  assign push_fire    = push_valid_o && push_ready_i;

  // Last slice written this cycle
  assign incr_done = slice_we && (slice_idx == ctr_pkg::LastSliceIdx);

  // Slice read for the adder
  assign slice_rd = ctr_q[slice_idx*ctr_pkg::SliceSize +: ctr_pkg::SliceSize];

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    rem_d   = rem_q;

    case (state_q)
      GEN_IDLE: begin
        // Zero count only loads the counter
        if (start_fire) begin
          rem_d = start_count_i;
          if (start_count_i != '0) begin
            state_d = GEN_PUSH;
          end
        end
      end
      GEN_PUSH: begin
        if (push_fire) begin
          rem_d   = rem_q - 1'b1;
          state_d = GEN_INCR;
        end
      end
      GEN_INCR: begin
        if (incr_done) begin
          state_d = (rem_q == '0) ? GEN_IDLE : GEN_PUSH;
        end
      end
      default: state_d = GEN_IDLE;
    endcase

    // Abandon the run on error
    if (alert_o) begin
      state_d = GEN_IDLE;
      rem_d   = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= GEN_IDLE;
      rem_q   <= '0;
    end else begin
      state_q <= state_d;
      rem_q   <= rem_d;
    end
  end

  // Counter block, updated in place one slice at a time
  always_ff @(posedge clk_i) begin
    if (start_fire) begin
      ctr_q <= start_iv_i;
    end else if (slice_we) begin
      ctr_q[slice_idx*ctr_pkg::SliceSize +: ctr_pkg::SliceSize] <= slice_wr;
    end
  end

  ////////////////////////////////////////////////////////////
  // Increment FSM
  ////////////////////////////////////////////////////////////

  ctr_incr_fsm i_incr_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .incr_i      (push_fire),
    .err_i       (err_i),
    .ready_o     (fsm_ready),
    .alert_o     (alert_o),
    .slice_idx_o (slice_idx),
    .slice_i     (slice_rd),
    .slice_o     (slice_wr),
    .slice_we_o  (slice_we)
  );

endmodule

`default_nettype wire

//--- src/ctr_incr_fsm.sv
/*
 * Slice-serial counter increment FSM
 * Adds one to the counter block a slice per cycle with a rippling carry,
 * and locks into a terminal error state that raises the alert
 */
`timescale 1ns/1ps
`default_nettype none

module ctr_incr_fsm (
  input  wire                                clk_i,
  input  wire                                rst_ni,

  // Handshake with the block generator
  input  wire                                incr_i,
  input  wire                                err_i,
  output logic                               ready_o,
  output logic                               alert_o,

  // Slice access into the generator's counter register
  output logic [ctr_pkg::SliceIdxWidth-1:0]  slice_idx_o,
  input  wire  [ctr_pkg::SliceSize-1:0]      slice_i,
  output logic [ctr_pkg::SliceSize-1:0]      slice_o,
  output logic                               slice_we_o
);

  ctr_pkg::ctr_state_e               state_d, state_q;
  logic [ctr_pkg::SliceIdxWidth-1:0] idx_d, idx_q;
  logic                              carry_d, carry_q;
  // One extra bit holds the carry-out
  logic [ctr_pkg::SliceSize:0]       sum;

  ////////////////////////////////////////////////////////////
  // Slice adder
  ////////////////////////////////////////////////////////////

  assign sum = {1'b0, slice_i} + {{ctr_pkg::SliceSize{1'b0}}, carry_q};

  assign slice_o     = sum[ctr_pkg::SliceSize-1:0];
  assign slice_idx_o = idx_q;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Defaults
    ready_o    = 1'b0;
    slice_we_o = 1'b0;
    alert_o    = 1'b0;
    state_d    = state_q;
    idx_d      = idx_q;
    carry_d    = carry_q;

    case (state_q)
      ctr_pkg::CTR_IDLE: begin
        ready_o = 1'b1;
        if (incr_i) begin
          // Start at the lowest slice, carry in of one
          idx_d   = '0;
          carry_d = 1'b1;
          state_d = ctr_pkg::CTR_INCR;
        end
      end

      ctr_pkg::CTR_INCR: begin
        slice_we_o = 1'b1;
        carry_d    = sum[ctr_pkg::SliceSize];
        idx_d      = idx_q + 1'b1;
        // Top slice written, increment complete
        if (idx_q == ctr_pkg::LastSliceIdx) begin
          state_d = ctr_pkg::CTR_IDLE;
        end
      end

      ctr_pkg::CTR_ERROR: begin
        // Terminal, left only by reset
        alert_o = 1'b1;
      end

      default: begin
        // Illegal encoding, fail safe
        alert_o = 1'b1;
        state_d = ctr_pkg::CTR_ERROR;
      end
    endcase

    // External integrity error overrides everything
    if (err_i) begin
      state_d = ctr_pkg::CTR_ERROR;
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ctr_pkg::CTR_IDLE;
      idx_q   <= '0;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
      carry_q <= carry_d;
    end
  end

endmodule

`default_nettype wire

//--- src/ctr_pkg.sv
/*
 * Counter-mode stream package
 * Counter block geometry, slice-serial increment sizing, block FIFO sizing
 * and the sparse state encoding of the increment FSM
 */
`default_nettype none

package ctr_pkg;

  ////////////////////////////////////////////////////////////
  // Counter block geometry
  ////////////////////////////////////////////////////////////

  // Full counter block, one cipher block wide
  localparam int unsigned CtrWidth = 128;

  // Increment granularity, one slice per clock
  localparam int unsigned SliceSize     = 16;
  localparam int unsigned NumSlices     = CtrWidth / SliceSize;
  localparam int unsigned SliceIdxWidth = 3;
  localparam logic [SliceIdxWidth-1:0] LastSliceIdx = SliceIdxWidth'(NumSlices - 1);

  // Output words, most significant first
  localparam int unsigned WordWidth     = 32;
  localparam int unsigned WordsPerBlock = CtrWidth / WordWidth;
  localparam int unsigned WordIdxWidth  = 2;
  localparam logic [WordIdxWidth-1:0] LastWordIdx = WordIdxWidth'(WordsPerBlock - 1);

  // Requested number of blocks per run
  localparam int unsigned CountWidth = 8;

  ////////////////////////////////////////////////////////////
  // Block FIFO sizing
  ////////////////////////////////////////////////////////////

  localparam int unsigned FifoDepth    = 2;
  localparam int unsigned FifoPtrWidth = 1;
  localparam int unsigned FifoCntWidth = 2;
  localparam logic [FifoPtrWidth-1:0] LastFifoPtr = FifoPtrWidth'(FifoDepth - 1);
  localparam logic [FifoCntWidth-1:0] FifoFullCnt = FifoCntWidth'(FifoDepth);

  ////////////////////////////////////////////////////////////
  // Sparse increment FSM encoding
  ////////////////////////////////////////////////////////////

  // Pairwise Hamming distance of at least 3
  typedef enum logic [5:0] {
    CTR_IDLE  = 6'b001001,
    CTR_INCR  = 6'b100011,
    CTR_ERROR = 6'b010100
  } ctr_state_e;

endpackage

`default_nettype wire
